// ==== include/mac_rx_defs.svh ====
// widths, depths and frame constants for the RMII receive MAC
// shared by the package and the design modules

`ifndef MAC_RX_DEFS_SVH
`define MAC_RX_DEFS_SVH

// ------------------------------
// byte and frame sizes
// ------------------------------
`define MAC_BYTE_W          8
`define MAC_MAX_FRAME_BYTES 1518
`define MAC_LEN_W           11

// idle cycles without a valid dibit that close a frame
`define MAC_IDLE_END        63
`define MAC_IDLE_W          6

// 7 x 0x55 then 0xD5, first dibit in bits [1:0]
`define MAC_PREAMBLE_SFD    64'hD555_5555_5555_5555

// good-frame residue, msb-first form
`define MAC_CRC_RESIDUE     32'hC704_DD7B

// ------------------------------
// buffer depths
// ------------------------------
`define MAC_DATA_FIFO_DEPTH 2048
`define MAC_RES_FIFO_DEPTH  16

`endif

// ==== design/mac_rx_pkg.sv ====
// types shared by the receive MAC blocks
// byte stream between stages and the stored FIFO entry

`include "mac_rx_defs.svh"

package mac_rx_pkg;

	// one byte of a frame on the internal stream
	typedef struct packed {
		logic                   sop;
		logic                   eop;
		logic                   vld;
		logic [`MAC_BYTE_W-1:0] data;
	} mac_byte_t;

	// frame FIFO word, sop in the top bit
	typedef struct packed {
		logic                   sop;
		logic                   eop;
		logic [`MAC_BYTE_W-1:0] data;
	} mac_fifo_entry_t;

endpackage

// ==== design/sync_fifo.sv ====
// single-clock FIFO with a registered read port

`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             i_clk,
	input  logic             i_rst_n,
	input  logic             i_wr,
	input  logic [WIDTH-1:0] i_wdat,
	input  logic             i_rd,
	output logic [WIDTH-1:0] o_rdat,
	output logic             o_empty,
	output logic             o_full
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [AW:0]      count;
	logic             wr_ok;
	logic             rd_ok;

	assign o_empty = (count == '0);
	assign o_full  = (count == (AW+1)'(DEPTH));
	assign wr_ok   = i_wr && !o_full;
	assign rd_ok   = i_rd && !o_empty;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_ok, rd_ok})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// storage and read data
	always_ff @(posedge i_clk) begin
		if (wr_ok)
			mem[wr_ptr] <= i_wdat;
		if (rd_ok)
			o_rdat <= mem[rd_ptr];
	end

endmodule

// ==== design/rmii_frame_detect.sv ====
// RMII input stage: preamble/SFD search, frame window and byte assembly
// bytes are held back one step so the last one can carry eop

`timescale 1ns/1ps
`include "mac_rx_defs.svh"

module rmii_frame_detect (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_rmii_rx_vld,
	input  logic [1:0]            i_rmii_rx_dat,
	output mac_rx_pkg::mac_byte_t o_byte
);

	logic                   rx_vld_q;
	logic [1:0]             rx_dat_q;
	logic [63:0]            window;
	logic [63:0]            window_next;
	logic                   sfd_hit;
	logic                   in_frame;
	logic                   first_byte;
	logic [1:0]             dibit_cnt;
	logic [`MAC_BYTE_W-1:0] asm_dat;
	logic [`MAC_BYTE_W-1:0] asm_next;
	logic [`MAC_LEN_W-1:0]  byte_cnt;
	logic [`MAC_IDLE_W-1:0] idle_cnt;
	logic                   byte_done;
	logic                   len_hit;
	logic                   idle_hit;
	logic                   flush;
	logic                   held_vld;
	logic                   held_sop;
	logic [`MAC_BYTE_W-1:0] held_dat;
	logic                   out_vld;
	logic                   out_sop;
	logic                   out_eop;
	logic [`MAC_BYTE_W-1:0] out_dat;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rx_vld_q <= 1'b0;
		end else begin
			rx_vld_q <= i_rmii_rx_vld;
		end
	end

	always_ff @(posedge i_clk) begin
		rx_dat_q <= i_rmii_rx_dat;
	end

	// ------------------------------
	// preamble search
	// ------------------------------
	// newest dibit enters at the top, so bytes line up low dibit first
	assign window_next = {rx_dat_q, window[63:2]};
	assign sfd_hit     = rx_vld_q && !in_frame && (window_next == `MAC_PREAMBLE_SFD);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			window <= '0;
		end else if (rx_vld_q) begin
			window <= window_next;
		end
	end

	// ------------------------------
	// frame window and counters
	// ------------------------------
	assign asm_next  = {rx_dat_q, asm_dat[`MAC_BYTE_W-1:2]};
	assign byte_done = in_frame && rx_vld_q && (dibit_cnt == 2'd3);
	assign len_hit   = byte_done && (byte_cnt == `MAC_LEN_W'(`MAC_MAX_FRAME_BYTES - 1));
	assign idle_hit  = in_frame && !rx_vld_q && (idle_cnt == `MAC_IDLE_W'(`MAC_IDLE_END - 1));

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			in_frame   <= 1'b0;
			first_byte <= 1'b0;
			dibit_cnt  <= '0;
			byte_cnt   <= '0;
			idle_cnt   <= '0;
			flush      <= 1'b0;
		end else begin
			flush <= len_hit || idle_hit;
			if (sfd_hit) begin
				in_frame   <= 1'b1;
				first_byte <= 1'b1;
				dibit_cnt  <= '0;
				byte_cnt   <= '0;
				idle_cnt   <= '0;
			end else if (in_frame) begin
				// a length close drops the rest until the next preamble
				if (len_hit || idle_hit)
					in_frame <= 1'b0;
				if (rx_vld_q) begin
					dibit_cnt <= dibit_cnt + 2'd1;
					idle_cnt  <= '0;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
				if (byte_done) begin
					byte_cnt   <= byte_cnt + 1'b1;
					first_byte <= 1'b0;
				end
			end
		end
	end

	// ------------------------------
	// hold stage and output
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			held_vld <= 1'b0;
			held_sop <= 1'b0;
			out_vld  <= 1'b0;
			out_sop  <= 1'b0;
			out_eop  <= 1'b0;
		end else begin
			out_vld <= 1'b0;
			out_sop <= 1'b0;
			out_eop <= 1'b0;
			if (byte_done) begin
				held_vld <= 1'b1;
				held_sop <= first_byte;
				out_vld  <= held_vld;
				out_sop  <= held_vld && held_sop;
			end else if (flush) begin
				// frame closed: release the held byte as the last one
				held_vld <= 1'b0;
				out_vld  <= held_vld;
				out_sop  <= held_vld && held_sop;
				out_eop  <= held_vld;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (rx_vld_q)
			asm_dat <= asm_next;
		if (byte_done)
			held_dat <= asm_next;
		if (byte_done || flush)
			out_dat <= held_dat;
	end

	assign o_byte = '{sop: out_sop, eop: out_eop, vld: out_vld, data: out_dat};

endmodule

// ==== design/frame_crc_check.sv ====
// byte-wise CRC-32 over each frame and the residue compare at eop

`timescale 1ns/1ps
`include "mac_rx_defs.svh"

module frame_crc_check (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  mac_rx_pkg::mac_byte_t i_byte,
	output logic                  o_res_wr,
	output logic                  o_crc_ok
);

	localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;

	logic [31:0] crc_q;
	logic [31:0] crc_base;
	logic [31:0] crc_next;
	logic [31:0] crc_msb;

	// reflected update, lsb of the byte first
	function automatic logic [31:0] crc32_step(input logic [31:0] crc,
	                                           input logic [7:0]  dat);
		logic [31:0] c;
		int          i;
		c = crc ^ {24'd0, dat};
		for (i = 0; i < 8; i++) begin
			c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
		end
		return c;
	endfunction

	// sop restarts from all ones
	assign crc_base = i_byte.sop ? 32'hFFFF_FFFF : crc_q;
	assign crc_next = crc32_step(crc_base, i_byte.data);

	// register is bit-reflected, residue is given msb first
	assign crc_msb = {<<{crc_next}};

	always_ff @(posedge i_clk) begin
		if (i_byte.vld)
			crc_q <= crc_next;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_res_wr <= 1'b0;
			o_crc_ok <= 1'b0;
		end else begin
			o_res_wr <= i_byte.vld && i_byte.eop;
			o_crc_ok <= i_byte.vld && i_byte.eop && (crc_msb == `MAC_CRC_RESIDUE);
		end
	end

endmodule

// ==== design/frame_read_ctrl.sv ====
// stored-frame count, read scheduling and the output registers

`timescale 1ns/1ps
`include "mac_rx_defs.svh"

module frame_read_ctrl (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_frame_stored,
	input  mac_rx_pkg::mac_fifo_entry_t i_data_rdat,
	input  logic                        i_res_empty,
	input  logic                        i_res_ok,
	output logic                        o_data_rd,
	output logic                        o_res_rd,
	output logic                        o_mac_packet_rx_sop,
	output logic                        o_mac_packet_rx_eop,
	output logic                        o_mac_packet_rx_vld,
	output logic [7:0]                  o_mac_packet_rx_dat,
	output logic                        o_mac_packet_rx_crc_ok
);

	localparam int CNT_W = $clog2(`MAC_RES_FIFO_DEPTH) + 1;

	logic [CNT_W-1:0] frame_cnt;
	logic             rd_flag;
	logic             rd_q;
	logic             res_rd_q;
	logic             ok_hold;
	logic             start;
	logic             last_seen;

	// a frame starts only once its result is waiting too
	assign start     = (frame_cnt != '0) && !i_res_empty && !rd_flag;
	assign last_seen = rd_q && i_data_rdat.eop;
	assign o_res_rd  = start;
	// stop as soon as the eop entry shows up on the read port
	assign o_data_rd = rd_flag && !last_seen;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			frame_cnt <= '0;
			rd_flag   <= 1'b0;
			rd_q      <= 1'b0;
			res_rd_q  <= 1'b0;
		end else begin
			case ({i_frame_stored, last_seen})
				2'b10:   frame_cnt <= frame_cnt + 1'b1;
				2'b01:   frame_cnt <= frame_cnt - 1'b1;
				default: frame_cnt <= frame_cnt;
			endcase
			if (start)
				rd_flag <= 1'b1;
			else if (last_seen)
				rd_flag <= 1'b0;
			rd_q     <= o_data_rd;
			res_rd_q <= o_res_rd;
		end
	end

	// ------------------------------
	// output registers
	// ------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			ok_hold                <= 1'b0;
			o_mac_packet_rx_sop    <= 1'b0;
			o_mac_packet_rx_eop    <= 1'b0;
			o_mac_packet_rx_vld    <= 1'b0;
			o_mac_packet_rx_crc_ok <= 1'b0;
		end else begin
			if (res_rd_q)
				ok_hold <= i_res_ok;
			o_mac_packet_rx_sop    <= rd_q && i_data_rdat.sop;
			o_mac_packet_rx_eop    <= last_seen;
			o_mac_packet_rx_vld    <= rd_q;
			o_mac_packet_rx_crc_ok <= last_seen && ok_hold;
		end
	end

	always_ff @(posedge i_clk) begin
		o_mac_packet_rx_dat <= i_data_rdat.data;
	end

endmodule

// ==== design/mac_rx_top.sv ====
// RMII receive MAC top: detector, CRC check, frame and result FIFOs
// and the read controller

`timescale 1ns/1ps
`include "mac_rx_defs.svh"

module mac_rx_top (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_rmii_rx_vld,
	input  logic [1:0] i_rmii_rx_dat,
	output logic       o_mac_packet_rx_sop,
	output logic       o_mac_packet_rx_eop,
	output logic       o_mac_packet_rx_vld,
	output logic [7:0] o_mac_packet_rx_dat,
	output logic       o_mac_packet_rx_crc_ok
);

	mac_rx_pkg::mac_byte_t       det_byte;
	mac_rx_pkg::mac_fifo_entry_t data_wdat;
	mac_rx_pkg::mac_fifo_entry_t data_rdat;
	logic                        frame_stored;
	logic                        data_rd;
	logic                        res_wr;
	logic                        res_crc_ok;
	logic                        res_rd;
	logic                        res_empty;
	logic                        res_ok;

	assign data_wdat    = '{sop: det_byte.sop, eop: det_byte.eop, data: det_byte.data};
	assign frame_stored = det_byte.vld && det_byte.eop;

	rmii_frame_detect detect_i (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_rmii_rx_vld (i_rmii_rx_vld),
		.i_rmii_rx_dat (i_rmii_rx_dat),
		.o_byte        (det_byte)
	);

	frame_crc_check crc_i (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_byte   (det_byte),
		.o_res_wr (res_wr),
		.o_crc_ok (res_crc_ok)
	);

	// frame bytes
	sync_fifo #(
		.WIDTH ($bits(mac_rx_pkg::mac_fifo_entry_t)),
		.DEPTH (`MAC_DATA_FIFO_DEPTH)
	) data_fifo_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_wr    (det_byte.vld),
		.i_wdat  (data_wdat),
		.i_rd    (data_rd),
		.o_rdat  (data_rdat),
		.o_empty (),
		.o_full  ()
	);

	// one check result per frame
	sync_fifo #(
		.WIDTH (1),
		.DEPTH (`MAC_RES_FIFO_DEPTH)
	) res_fifo_i (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_wr    (res_wr),
		.i_wdat  (res_crc_ok),
		.i_rd    (res_rd),
		.o_rdat  (res_ok),
		.o_empty (res_empty),
		.o_full  ()
	);

	frame_read_ctrl read_i (
		.i_clk                  (i_clk),
		.i_rst_n                (i_rst_n),
		.i_frame_stored         (frame_stored),
		.i_data_rdat            (data_rdat),
		.i_res_empty            (res_empty),
		.i_res_ok               (res_ok),
		.o_data_rd              (data_rd),
		.o_res_rd               (res_rd),
		.o_mac_packet_rx_sop    (o_mac_packet_rx_sop),
		.o_mac_packet_rx_eop    (o_mac_packet_rx_eop),
		.o_mac_packet_rx_vld    (o_mac_packet_rx_vld),
		.o_mac_packet_rx_dat    (o_mac_packet_rx_dat),
		.o_mac_packet_rx_crc_ok (o_mac_packet_rx_crc_ok)
	);

endmodule

// ==== test/mac_rx_checker.sv ====
// output monitor for the receive MAC
// collects each frame from sop to eop, compares bytes, length and crc_ok

`timescale 1ns/1ps

module mac_rx_checker (
	input  logic       i_clk,
	input  logic       i_sop,
	input  logic       i_eop,
	input  logic       i_vld,
	input  logic [7:0] i_dat,
	input  logic       i_crc_ok,
	output int         o_frames,
	output int         o_checks,
	output int         o_errors
);

	logic [7:0] exp_bytes[$];
	int         exp_len[$];
	logic       exp_ok[$];
	logic [7:0] got_bytes[$];
	logic       in_frame     = 1'b0;
	logic       any_expected = 1'b0;
	int         frames       = 0;
	int         checks       = 0;
	int         errors       = 0;

	assign o_frames = frames;
	assign o_checks = checks;
	assign o_errors = errors;

	// filled by the testbench before each frame is sent
	task automatic add_expected_byte(input logic [7:0] b);
		exp_bytes.push_back(b);
	endtask

	task automatic add_expected_frame(input int len, input logic ok);
		exp_len.push_back(len);
		exp_ok.push_back(ok);
		any_expected = 1'b1;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
	                           input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[FAIL] %0t ns: %s expected 0x%0h, got 0x%0h",
			         $time, name, expected, actual);
		end
	endtask

	// ------------------------------
	// frame compare at eop
	// ------------------------------
	task automatic compare_frame();
		int         len;
		int         i;
		logic [7:0] e;
		frames++;
		if (exp_len.size() == 0) begin
			errors++;
			$display("[%0t ns] a frame of %0d bytes came out but none was expected",
			         $time, got_bytes.size());
		end else begin
			len = exp_len.pop_front();
			check_value("frame length", len, got_bytes.size());
			for (i = 0; i < len; i++) begin
				e = exp_bytes.pop_front();
				if (i < got_bytes.size())
					check_value($sformatf("o_mac_packet_rx_dat[byte %0d]", i), e, got_bytes[i]);
			end
			check_value("o_mac_packet_rx_crc_ok", exp_ok.pop_front(), i_crc_ok);
		end
	endtask

	// outputs change on the rising edge, so sample on the falling one
	always @(negedge i_clk) begin
		// quiet until the first frame goes in
		if (!any_expected) begin
			check_value("o_mac_packet_rx_vld", 32'd0, {31'd0, i_vld});
			check_value("o_mac_packet_rx_sop", 32'd0, {31'd0, i_sop});
			check_value("o_mac_packet_rx_eop", 32'd0, {31'd0, i_eop});
		end
		if (i_vld === 1'b1) begin
			if (i_sop === 1'b1) begin
				if (in_frame) begin
					errors++;
					$display("[%0t ns] sop came out inside an open frame", $time);
				end
				in_frame = 1'b1;
				got_bytes.delete();
			end
			if (in_frame) begin
				got_bytes.push_back(i_dat);
				if (i_eop === 1'b1) begin
					compare_frame();
					in_frame = 1'b0;
				end
			end else begin
				errors++;
				$display("[%0t ns] a byte came out with no sop before it", $time);
			end
		end else if (any_expected && (i_sop === 1'b1 || i_eop === 1'b1)) begin
			errors++;
			$display("[%0t ns] sop or eop is high while vld is low", $time);
		end
	end

endmodule

// ==== test/tb_mac_rx.sv ====
// testbench top for the RMII receive MAC
// clock, reset, LFSR stimulus, reference CRC, frame builder and test sequence

`timescale 1ns/1ps
`include "mac_rx_defs.svh"

module tb_mac_rx;

	localparam int          WAIT_LIMIT = 5000;
	localparam logic [31:0] LFSR_TAPS  = 32'hD000_0001;
	localparam logic [31:0] CRC_POLY   = 32'h04C1_1DB7;

	logic        clk    = 1'b0;
	logic        rst_n  = 1'b0;
	logic        rx_vld = 1'b0;
	logic [1:0]  rx_dat = 2'b00;
	logic        out_sop;
	logic        out_eop;
	logic        out_vld;
	logic [7:0]  out_dat;
	logic        out_crc_ok;
	int          frames;
	int          checks;
	int          errors;
	logic [31:0] lfsr = 32'd29;
	logic [7:0]  tx_bytes[$];
	int          frames_expected = 0;
	int          tests_run       = 0;
	int          tests_failed    = 0;
	int          errors_before   = 0;
	logic        timed_out       = 1'b0;

	always #5 clk = ~clk;

	mac_rx_top dut_i (
		.i_clk                  (clk),
		.i_rst_n                (rst_n),
		.i_rmii_rx_vld          (rx_vld),
		.i_rmii_rx_dat          (rx_dat),
		.o_mac_packet_rx_sop    (out_sop),
		.o_mac_packet_rx_eop    (out_eop),
		.o_mac_packet_rx_vld    (out_vld),
		.o_mac_packet_rx_dat    (out_dat),
		.o_mac_packet_rx_crc_ok (out_crc_ok)
	);

	mac_rx_checker chk_i (
		.i_clk    (clk),
		.i_sop    (out_sop),
		.i_eop    (out_eop),
		.i_vld    (out_vld),
		.i_dat    (out_dat),
		.i_crc_ok (out_crc_ok),
		.o_frames (frames),
		.o_checks (checks),
		.o_errors (errors)
	);

	// ------------------------------
	// random bits and reference CRC
	// ------------------------------
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			v[i] = lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// serial CRC-32 with an msb-first register and each byte fed lsb first
	function automatic logic [31:0] crc32_ref(input int count);
		logic [31:0] crc;
		logic        fb;
		int          i;
		int          k;
		crc = 32'hFFFF_FFFF;
		for (i = 0; i < count; i++) begin
			for (k = 0; k < 8; k++) begin
				fb  = crc[31] ^ tx_bytes[i][k];
				crc = {crc[30:0], 1'b0} ^ (fb ? CRC_POLY : 32'd0);
			end
		end
		return crc;
	endfunction

	// payload from the LFSR and then the FCS with x^31 sent first
	task automatic build_frame(input int n_payload, input logic flip_fcs);
		logic [31:0] v;
		logic [31:0] fcs;
		logic [7:0]  b;
		int          i;
		int          k;
		tx_bytes.delete();
		for (i = 0; i < n_payload; i++) begin
			take_bits(8, v);
			tx_bytes.push_back(v[7:0]);
		end
		fcs = ~crc32_ref(n_payload);
		for (i = 0; i < 4; i++) begin
			for (k = 0; k < 8; k++)
				b[k] = fcs[31 - 8*i - k];
			tx_bytes.push_back(b);
		end
		if (flip_fcs)
			tx_bytes[n_payload + 1] = tx_bytes[n_payload + 1] ^ 8'h08;
	endtask

	task automatic expect_frame(input int n_out);
		int i;
		for (i = 0; i < n_out; i++)
			chk_i.add_expected_byte(tx_bytes[i]);
		chk_i.add_expected_frame(n_out, crc32_ref(n_out) == `MAC_CRC_RESIDUE);
		frames_expected++;
	endtask

	// ------------------------------
	// RMII drive with the low dibit first
	// ------------------------------
	task automatic drive_dibit(input logic [1:0] d);
		@(negedge clk);
		rx_vld = 1'b1;
		rx_dat = d;
	endtask

	// idle cycles carry noise on the data pins
	task automatic drive_idle(input int cycles);
		logic [31:0] v;
		int          i;
		for (i = 0; i < cycles; i++) begin
			take_bits(2, v);
			@(negedge clk);
			rx_vld = 1'b0;
			rx_dat = v[1:0];
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		drive_dibit(b[1:0]);
		drive_dibit(b[3:2]);
		drive_dibit(b[5:4]);
		drive_dibit(b[7:6]);
	endtask

	task automatic send_frame(input int noise, input int gap_at, input int gap_len,
	                          input int trail);
		logic [31:0] v;
		int          i;
		for (i = 0; i < noise; i++) begin
			take_bits(2, v);
			drive_dibit(v[1:0]);
		end
		for (i = 0; i < 7; i++)
			send_byte(8'h55);
		send_byte(8'hD5);
		for (i = 0; i < tx_bytes.size(); i++) begin
			if (i == gap_at) begin
				// valid drops in the middle of a byte
				drive_dibit(tx_bytes[i][1:0]);
				drive_dibit(tx_bytes[i][3:2]);
				drive_idle(gap_len);
				drive_dibit(tx_bytes[i][5:4]);
				drive_dibit(tx_bytes[i][7:6]);
			end else begin
				send_byte(tx_bytes[i]);
			end
		end
		for (i = 0; i < trail; i++) begin
			take_bits(2, v);
			drive_dibit(v[1:0]);
		end
		drive_idle(80);
	endtask

	// ------------------------------
	// waits and reporting
	// ------------------------------
	task automatic end_run();
		$display("tests %0d, failed %0d, frames %0d of %0d, checks %0d, errors %0d",
		         tests_run, tests_failed, frames, frames_expected, checks, errors);
		if (!timed_out && tests_failed == 0 && errors == 0 && frames == frames_expected)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic wait_frames(input string name);
		int n;
		n = 0;
		while (frames < frames_expected && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (frames < frames_expected) begin
			$display("timeout in %s: only %0d of %0d frames came out within %0d cycles",
			         name, frames, frames_expected, WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic finish_test(input string name);
		@(posedge clk);
		tests_run++;
		if (timed_out) begin
			tests_failed++;
			$display("test %s did not finish before the timeout", name);
		end else if (errors != errors_before) begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, errors - errors_before);
		end else begin
			$display("test %s passed", name);
		end
		errors_before = errors;
	endtask

	task automatic run_tests();
		logic [31:0] v;
		int          len;
		int          i;
		drive_idle(20);
		finish_test("reset_state");

		build_frame(60, 1'b0);
		expect_frame(64);
		drive_idle(10);
		send_frame(0, -1, 0, 0);
		wait_frames("good_frame");
		finish_test("good_frame");
		if (timed_out)
			return;

		build_frame(60, 1'b1);
		expect_frame(64);
		send_frame(0, -1, 0, 0);
		wait_frames("bad_fcs");
		finish_test("bad_fcs");
		if (timed_out)
			return;

		// noise before the preamble plus a gap inside and stray dibits at the end
		for (i = 0; i < 3; i++) begin
			take_bits(8, v);
			len = 64 + int'(v) % 137;
			build_frame(len - 4, 1'b0);
			expect_frame(len);
			take_bits(8, v);
			send_frame(1 + int'(v[2:0]), len / 2, 10 + int'(v[5:3]) * 5,
			           1 + int'(v[7:6]) % 3);
		end
		wait_frames("back_to_back");
		finish_test("back_to_back");
		if (timed_out)
			return;

		build_frame(1596, 1'b0);
		expect_frame(`MAC_MAX_FRAME_BYTES);
		send_frame(0, -1, 0, 0);
		wait_frames("over_long");
		drive_idle(100);
		finish_test("over_long");
	endtask

	initial begin
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		run_tests();
		end_run();
	end

endmodule

// ==== sim.f ====
+incdir+include
design/mac_rx_pkg.sv
design/sync_fifo.sv
design/rmii_frame_detect.sv
design/frame_crc_check.sv
design/frame_read_ctrl.sv
design/mac_rx_top.sv
test/mac_rx_checker.sv
test/tb_mac_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive MAC testbench with Verilator
rm -f sim.log
verilator --binary -Wno-fatal -f sim.f --top-module tb_mac_rx -Mdir obj_dir \
	&& ./obj_dir/Vtb_mac_rx > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qs "TEST RESULT: PASS" sim.log && exit 0 || exit 1
